//--- lsu_agu.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_agu (
  input  lsu_pkg::lsu_issue_t issue_i,
  output lsu_pkg::lsu_req_t   req_o
);

  lsu_pkg::xlen_t addr;
  lsu_pkg::be_t   be_base;
  logic           is_half;
  logic           is_word;
  logic           misaligned;

  // Immediate arrives already sign-extended to full width
  assign addr = issue_i.operand_a + issue_i.imm;

  // ----------------------------------------
  // Transfer size
  // ----------------------------------------
  always_comb begin
    is_half = 1'b0;
    is_word = 1'b0;
    be_base = lsu_pkg::be_t'(1);
    unique case (issue_i.op)
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: begin
        is_half = 1'b1;
        be_base = lsu_pkg::be_t'(3);
      end
      lsu_pkg::LW, lsu_pkg::SW: begin
        is_word = 1'b1;
        be_base = '1;
      end
      // Bytes are never misaligned
      default: ;
    endcase
  end

  // Halfwords need an even address, words a multiple of 4
  assign misaligned = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

  // ----------------------------------------
  // Decoded request
  // ----------------------------------------
  always_comb begin
    req_o.op         = issue_i.op;
    req_o.addr       = addr;
    req_o.be         = be_base << addr[1:0];
    req_o.wdata      = issue_i.operand_b;
    req_o.trans_id   = issue_i.trans_id;
    req_o.misaligned = misaligned;
  end

endmodule

//--- lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// ----------------------------------------
// Datapath sizes
// ----------------------------------------
`define LSU_XLEN 32
`define LSU_TRANS_ID_BITS 3

// Entries in the issue-side request queue
`define LSU_QUEUE_DEPTH 2

// ----------------------------------------
// Exception causes
// ----------------------------------------
`define LSU_CAUSE_BITS 5
`define LSU_CAUSE_LD_MISALIGNED 4
`define LSU_CAUSE_ST_MISALIGNED 6

`endif

//--- lsu_ctrl.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_req_t    head_i,
  input  logic                 head_valid_i,
  input  logic                 mem_ack_i,
  input  lsu_pkg::xlen_t       mem_rdata_i,
  output logic                 pop_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  output logic                 mem_req_valid_o,
  output logic                 load_valid_o,
  output lsu_pkg::lsu_result_t load_result_o,
  output logic                 store_valid_o,
  output lsu_pkg::lsu_result_t store_result_o
);

  lsu_pkg::ctrl_state_e state_q;
  lsu_pkg::ctrl_state_e state_d;
  lsu_pkg::xlen_t       rdata_aligned;
  lsu_pkg::xlen_t       wdata_aligned;
  lsu_pkg::xlen_t       rdata_q;
  lsu_pkg::lsu_exc_t    exc;
  logic                 is_store;

  assign is_store = head_i.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

  lsu_data_align i_data_align (
    .op_i       (head_i.op),
    .byte_off_i (head_i.addr[1:0]),
    .wdata_i    (head_i.wdata),
    .rdata_i    (mem_rdata_i),
    .wdata_o    (wdata_aligned),
    .rdata_o    (rdata_aligned)
  );

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lsu_pkg::IDLE: begin
        if (head_valid_i) begin
          // Misaligned entries never touch memory
          if (head_i.misaligned) begin
            state_d = lsu_pkg::RESULT;
          end else begin
            state_d = lsu_pkg::MEM_REQ;
          end
        end
      end
      lsu_pkg::MEM_REQ: begin
        if (mem_ack_i) begin
          state_d = lsu_pkg::MEM_RELEASE;
        end
      end
      // Wait for ack low before the next request can go out
      lsu_pkg::MEM_RELEASE: begin
        if (!mem_ack_i) begin
          state_d = lsu_pkg::RESULT;
        end
      end
      default: begin
        state_d = lsu_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lsu_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Load data is valid together with ack
  always_ff @(posedge clk_i) begin
    if ((state_q == lsu_pkg::MEM_REQ) && mem_ack_i) begin
      rdata_q <= rdata_aligned;
    end
  end

  // ----------------------------------------
  // Memory port
  // ----------------------------------------
  assign mem_req_valid_o = (state_q == lsu_pkg::MEM_REQ);

  always_comb begin
    mem_req_o.addr  = head_i.addr;
    mem_req_o.we    = is_store;
    mem_req_o.be    = head_i.be;
    mem_req_o.wdata = wdata_aligned;
  end

  // ----------------------------------------
  // Results
  // ----------------------------------------
  always_comb begin
    exc = '0;
    if (head_i.misaligned) begin
      exc.valid = 1'b1;
      exc.cause = is_store ? lsu_pkg::cause_t'(`LSU_CAUSE_ST_MISALIGNED)
                           : lsu_pkg::cause_t'(`LSU_CAUSE_LD_MISALIGNED);
      exc.tval  = head_i.addr;
    end
  end

  // Head entry retires in the same cycle as its result pulse
  assign pop_o         = (state_q == lsu_pkg::RESULT);
  assign load_valid_o  = pop_o && !is_store;
  assign store_valid_o = pop_o && is_store;

  always_comb begin
    load_result_o.trans_id  = head_i.trans_id;
    load_result_o.data      = exc.valid ? '0 : rdata_q;
    load_result_o.exc       = exc;
    store_result_o.trans_id = head_i.trans_id;
    store_result_o.data     = '0;
    store_result_o.exc      = exc;
  end

  // Request and payload hold until memory acks
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_ack_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

//--- lsu_data_align.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_data_align (
  input  lsu_pkg::lsu_op_e op_i,
  input  logic [1:0]       byte_off_i,
  input  lsu_pkg::xlen_t   wdata_i,
  input  lsu_pkg::xlen_t   rdata_i,
  output lsu_pkg::xlen_t   wdata_o,
  output lsu_pkg::xlen_t   rdata_o
);

  lsu_pkg::xlen_t rdata_shifted;

  // ----------------------------------------
  // Store path
  // ----------------------------------------
  // Byte offset picks the lane, upper bits fall off for narrow stores
  assign wdata_o = wdata_i << {byte_off_i, 3'b000};

  // ----------------------------------------
  // Load path
  // ----------------------------------------
  assign rdata_shifted = rdata_i >> {byte_off_i, 3'b000};

  always_comb begin
    unique case (op_i)
      lsu_pkg::LB: begin
        rdata_o = {{(`LSU_XLEN - 8){rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      lsu_pkg::LBU: begin
        rdata_o = {{(`LSU_XLEN - 8){1'b0}}, rdata_shifted[7:0]};
      end
      lsu_pkg::LH: begin
        rdata_o = {{(`LSU_XLEN - 16){rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      lsu_pkg::LHU: begin
        rdata_o = {{(`LSU_XLEN - 16){1'b0}}, rdata_shifted[15:0]};
      end
      // Word loads pass through as is
      default: begin
        rdata_o = rdata_shifted;
      end
    endcase
  end

endmodule

//--- lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0]          xlen_t;
  typedef logic [`LSU_XLEN/8-1:0]        be_t;
  typedef logic [`LSU_TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [`LSU_CAUSE_BITS-1:0]    cause_t;

  // Loads first, then stores
  typedef enum logic [2:0] {
    LB, LBU, LH, LHU, LW, SB, SH, SW
  } lsu_op_e;

  typedef enum logic [1:0] {
    IDLE, MEM_REQ, MEM_RELEASE, RESULT
  } ctrl_state_e;

  // ----------------------------------------
  // Structs that cross module boundaries
  // ----------------------------------------
  typedef struct packed {
    lsu_op_e   op;
    xlen_t     operand_a;
    xlen_t     imm;
    xlen_t     operand_b;
    trans_id_t trans_id;
  } lsu_issue_t;

  // Decoded entry, store data not yet moved into its lanes
  typedef struct packed {
    lsu_op_e   op;
    xlen_t     addr;
    be_t       be;
    xlen_t     wdata;
    trans_id_t trans_id;
    logic      misaligned;
  } lsu_req_t;

  typedef struct packed {
    xlen_t addr;
    logic  we;
    be_t   be;
    xlen_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic   valid;
    cause_t cause;
    xlen_t  tval;
  } lsu_exc_t;

  typedef struct packed {
    trans_id_t trans_id;
    xlen_t     data;
    lsu_exc_t  exc;
  } lsu_result_t;

endpackage

//--- lsu_req_queue.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_req_queue (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              pop_i,
  output logic              ready_o,
  output lsu_pkg::lsu_req_t head_o,
  output logic              head_valid_o
);

  localparam int unsigned PTR_W = $clog2(`LSU_QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(`LSU_QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`LSU_QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`LSU_QUEUE_DEPTH);

  lsu_pkg::lsu_req_t mem_q [`LSU_QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              wr_en;
  logic              rd_en;

  assign ready_o      = (count_q != FULL_CNT);
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];

  // Issue only counts as accepted while there is room
  assign wr_en = push_i && ready_o;
  assign rd_en = pop_i && head_valid_o;

  // ----------------------------------------
  // Pointers and fill level
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // Control must only retire an entry that is actually there
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> head_valid_o);

  // A write never lands on the entry still waiting at the head
  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en && head_valid_o |-> (wr_ptr_q != rd_ptr_q));

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_valid_i,
  input  lsu_pkg::lsu_issue_t  issue_i,
  output logic                 issue_ready_o,
  input  logic                 mem_ack_i,
  input  lsu_pkg::xlen_t       mem_rdata_i,
  output logic                 mem_req_valid_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  output logic                 load_valid_o,
  output lsu_pkg::lsu_result_t load_result_o,
  output logic                 store_valid_o,
  output lsu_pkg::lsu_result_t store_result_o
);

  lsu_pkg::lsu_req_t issue_req;
  lsu_pkg::lsu_req_t head;
  logic              head_valid;
  logic              pop;

  lsu_agu i_agu (
    .issue_i (issue_i),
    .req_o   (issue_req)
  );

  lsu_req_queue i_req_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (issue_valid_i),
    .req_i        (issue_req),
    .pop_i        (pop),
    .ready_o      (issue_ready_o),
    .head_o       (head),
    .head_valid_o (head_valid)
  );

  lsu_ctrl i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .head_i          (head),
    .head_valid_i    (head_valid),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .pop_o           (pop),
    .mem_req_o       (mem_req_o),
    .mem_req_valid_o (mem_req_valid_o),
    .load_valid_o    (load_valid_o),
    .load_result_o   (load_result_o),
    .store_valid_o   (store_valid_o),
    .store_result_o  (store_result_o)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_lsu -o Vtb_lsu

out="$(./obj_dir/Vtb_lsu)" || true
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- sim.f
+incdir+.
lsu_pkg.sv
lsu_agu.sv
lsu_req_queue.sv
lsu_data_align.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

//--- tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;

  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    lsu_pkg::xlen_t   a;
    lsu_pkg::xlen_t   imm;
    lsu_pkg::xlen_t   b;
    lsu_pkg::xlen_t   data;
    logic             exc;
    lsu_pkg::cause_t  cause;
  } row_t;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 issue_valid_i;
  lsu_pkg::lsu_issue_t  issue_i;
  logic                 issue_ready_o;
  logic                 mem_ack_i;
  lsu_pkg::xlen_t       mem_rdata_i;
  logic                 mem_req_valid_o;
  lsu_pkg::mem_req_t    mem_req_o;
  logic                 load_valid_o;
  lsu_pkg::lsu_result_t load_result_o;
  logic                 store_valid_o;
  lsu_pkg::lsu_result_t store_result_o;

  row_t           rows[$];
  lsu_pkg::xlen_t mem [16];
  logic [31:0]    lfsr = 32'h8a221556;
  int             req_count = 0;
  logic           saw_stall = 1'b0;

  lsu_top dut (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      report_failure($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic add_row(input lsu_pkg::lsu_op_e op, input lsu_pkg::xlen_t a,
                         input lsu_pkg::xlen_t imm, input lsu_pkg::xlen_t b,
                         input lsu_pkg::xlen_t data, input logic exc, input int cause);
    row_t r;
    r.op    = op;
    r.a     = a;
    r.imm   = imm;
    r.b     = b;
    r.data  = data;
    r.exc   = exc;
    r.cause = lsu_pkg::cause_t'(cause);
    rows.push_back(r);
  endtask

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  task automatic serve_request();
    int          delay;
    int          waited;
    logic [3:0]  idx;
    lfsr  = lfsr_next(lfsr);
    delay = int'(lfsr[0]);
    lfsr  = lfsr_next(lfsr);
    delay = delay + 2 * int'(lfsr[0]);
    repeat (delay) @(negedge clk_i);
    idx         = mem_req_o.addr[5:2];
    mem_rdata_i = mem[idx];
    if (mem_req_o.we) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req_o.be[b]) mem[idx][8*b +: 8] = mem_req_o.wdata[8*b +: 8];
      end
    end
    req_count++;
    mem_ack_i = 1'b1;
    waited    = 0;
    while (mem_req_valid_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > 20) report_failure("memory request was not released after ack");
    end
    mem_ack_i = 1'b0;
  endtask

  always @(negedge clk_i) begin
    if (rst_ni && mem_req_valid_o && !mem_ack_i) serve_request();
  end

  // ----------------------------------------
  // Driver and in-order checker
  // ----------------------------------------
  task automatic drive_rows();
    int waited;
    for (int i = 0; i < rows.size(); i++) begin
      issue_valid_i      = 1'b1;
      issue_i.op         = rows[i].op;
      issue_i.operand_a  = rows[i].a;
      issue_i.imm        = rows[i].imm;
      issue_i.operand_b  = rows[i].b;
      issue_i.trans_id   = lsu_pkg::trans_id_t'(i);
      waited = 0;
      // Ready only changes at the rising edge, so it is stable here
      while (!issue_ready_o) begin
        saw_stall = 1'b1;
        @(negedge clk_i);
        waited++;
        if (waited > 200) report_failure("issue_ready_o stayed low too long");
      end
      @(negedge clk_i);
    end
    issue_valid_i = 1'b0;
  endtask

  task automatic check_results();
    row_t                 r;
    lsu_pkg::lsu_result_t res;
    logic                 st;
    int                   waited;
    int                   aligned;
    aligned = 0;
    for (int i = 0; i < rows.size(); i++) begin
      r      = rows[i];
      waited = 0;
      while (!load_valid_o && !store_valid_o) begin
        @(negedge clk_i);
        waited++;
        if (waited > 200) report_failure($sformatf("no result for row %0d", i));
      end
      st  = r.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
      res = store_valid_o ? store_result_o : load_result_o;
      if (!r.exc) aligned++;
      check_value("load_valid_o", 32'(load_valid_o), 32'(!st));
      check_value("store_valid_o", 32'(store_valid_o), 32'(st));
      check_value("result trans_id", 32'(res.trans_id), 32'(i % 8));
      check_value("result exc.valid", 32'(res.exc.valid), 32'(r.exc));
      if (r.exc) begin
        check_value("result exc.cause", 32'(res.exc.cause), 32'(r.cause));
        check_value("result exc.tval", res.exc.tval, r.a + r.imm);
      end else begin
        check_value("result data", res.data, r.data);
      end
      // Misaligned rows must not reach memory
      check_value("memory request count", 32'(req_count), 32'(aligned));
      @(negedge clk_i);
    end
  endtask

  // ----------------------------------------
  // Stimulus table
  // ----------------------------------------
  task automatic build_table();
    add_row(lsu_pkg::SW,  32'h10, 32'h0, 32'h8F7E6D5C, 32'h0, 1'b0, 0);
    add_row(lsu_pkg::LW,  32'h10, 32'h0, 32'h0, 32'h8F7E6D5C, 1'b0, 0);
    add_row(lsu_pkg::LB,  32'h10, 32'h0, 32'h0, 32'h0000005C, 1'b0, 0);
    add_row(lsu_pkg::LB,  32'h14, 32'hFFFFFFFD, 32'h0, 32'h0000006D, 1'b0, 0);
    add_row(lsu_pkg::LBU, 32'h10, 32'h2, 32'h0, 32'h0000007E, 1'b0, 0);
    add_row(lsu_pkg::LB,  32'h10, 32'h3, 32'h0, 32'hFFFFFF8F, 1'b0, 0);
    add_row(lsu_pkg::LBU, 32'h10, 32'h3, 32'h0, 32'h0000008F, 1'b0, 0);
    add_row(lsu_pkg::LH,  32'h10, 32'h0, 32'h0, 32'h00006D5C, 1'b0, 0);
    add_row(lsu_pkg::LH,  32'h10, 32'h2, 32'h0, 32'hFFFF8F7E, 1'b0, 0);
    add_row(lsu_pkg::LHU, 32'h10, 32'h2, 32'h0, 32'h00008F7E, 1'b0, 0);
    add_row(lsu_pkg::SB,  32'h10, 32'h1, 32'h000000A5, 32'h0, 1'b0, 0);
    add_row(lsu_pkg::LW,  32'h10, 32'h0, 32'h0, 32'h8F7EA55C, 1'b0, 0);
    add_row(lsu_pkg::LH,  32'h20, 32'h1, 32'h0, 32'h0, 1'b1, `LSU_CAUSE_LD_MISALIGNED);
    add_row(lsu_pkg::LW,  32'h20, 32'h2, 32'h0, 32'h0, 1'b1, `LSU_CAUSE_LD_MISALIGNED);
    add_row(lsu_pkg::SH,  32'h20, 32'h3, 32'h0, 32'h0, 1'b1, `LSU_CAUSE_ST_MISALIGNED);
    add_row(lsu_pkg::SW,  32'h24, 32'h1, 32'h0, 32'h0, 1'b1, `LSU_CAUSE_ST_MISALIGNED);
    add_row(lsu_pkg::SH,  32'h08, 32'h2, 32'h1234BEEF, 32'h0, 1'b0, 0);
    add_row(lsu_pkg::LHU, 32'h08, 32'h2, 32'h0, 32'h0000BEEF, 1'b0, 0);
    add_row(lsu_pkg::LB,  32'h08, 32'h3, 32'h0, 32'hFFFFFFBE, 1'b0, 0);
    add_row(lsu_pkg::SW,  32'h40, 32'hFFFFFFFC, 32'h0BADF00D, 32'h0, 1'b0, 0);
    add_row(lsu_pkg::LW,  32'h3C, 32'h0, 32'h0, 32'h0BADF00D, 1'b0, 0);
    add_row(lsu_pkg::LHU, 32'h3C, 32'h2, 32'h0, 32'h00000BAD, 1'b0, 0);
    add_row(lsu_pkg::LB,  32'h3C, 32'h0, 32'h0, 32'h0000000D, 1'b0, 0);
  endtask

  initial begin
    rst_ni        = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    mem_ack_i     = 1'b0;
    mem_rdata_i   = '0;
    for (int i = 0; i < 16; i++) mem[i] = 32'hC3A5_0F00 ^ (32'(i) * 32'h0102_0408);
    build_table();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("mem_req_valid_o", 32'(mem_req_valid_o), 32'h0);
    check_value("load_valid_o", 32'(load_valid_o), 32'h0);
    check_value("store_valid_o", 32'(store_valid_o), 32'h0);
    check_value("issue_ready_o", 32'(issue_ready_o), 32'h1);
    fork
      drive_rows();
      check_results();
    join
    assert (saw_stall) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_failure("issue_ready_o never went low with a full queue");
    end
  end

endmodule
